/* rtl/devBus_consts.svh */
`ifndef DEVBUS_CONSTS_SVH
`define DEVBUS_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DEV_ADDR_WD  4              // Register offset bits inside a device.
`define DEV_TC       28'h000_07F0   // Timer/counter upper address.
`define DEV_IN32     28'h000_07F1   // Input port upper address.
`define DEV_OUT32    28'h000_07F2   // Output port upper address.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define TC_CTRL      4'd0           // Control register.
`define TC_PRESET    4'd1           // Reload value.
`define TC_COUNT     4'd2           // Current count, read only.
`define TC_EN_BIT    0              // Counter enable.
`define TC_MODE_BIT  1              // 0 is one-shot, 1 is auto-reload.
`define TC_IRQEN_BIT 3              // Interrupt enable.

`endif

/* rtl/devBusPkg.sv */
`default_nettype none

`include "devBus_consts.svh"

package devBusPkg;

    // Processor data word.
    typedef logic [31:0] wordT;

    // Register offset within one device.
    typedef logic [`DEV_ADDR_WD-1:0] devOffsetT;

    // Upper address bits that pick the device.
    typedef logic [31-`DEV_ADDR_WD:0] devSelT;

    // Timer/counter FSM states.
    typedef enum logic [1:0] {
        tcIdle,     // Stopped.
        tcLoad,     // Count takes the preset.
        tcCount,    // Counting down.
        tcInt       // Terminal count reached.
    } tcStateT;

endpackage

`default_nettype wire

/* rtl/devBusIf.sv */
`timescale 1ns/1ns
`default_nettype none

// One device port hanging off the bridge.
interface devBusIf;
    import devBusPkg::*;

    devOffsetT offset;      // Register offset inside the device.
    wordT      wd;          // Write data.
    logic      wen;         // Write strobe for this device only.
    wordT      rd;          // Read data back to the bridge.

    modport bridge (
        output offset,
        output wd,
        output wen,
        input  rd
    );

    modport device (
        input  offset,
        input  wd,
        input  wen,
        output rd
    );

endinterface

`default_nettype wire

/* rtl/busBridge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "devBus_consts.svh"

module busBridge (
    input  devBusPkg::wordT prAddr,
    input  devBusPkg::wordT prWd,
    input  logic            prWe,
    output devBusPkg::wordT prRd,
    devBusIf.bridge         tcBus,
    devBusIf.bridge         inBus,
    devBusIf.bridge         outBus
);
    import devBusPkg::*;

    devSelT    devSel;
    devOffsetT offset;
    logic      hitTc;
    logic      hitIn;
    logic      hitOut;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign devSel = prAddr[31:`DEV_ADDR_WD];
    assign offset = prAddr[`DEV_ADDR_WD-1:0];

    assign hitTc  = (devSel == `DEV_TC);        // Map entries never overlap.
    assign hitIn  = (devSel == `DEV_IN32);
    assign hitOut = (devSel == `DEV_OUT32);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Downstream fan-out
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign tcBus.offset  = offset;
    assign inBus.offset  = offset;
    assign outBus.offset = offset;

    assign tcBus.wd  = prWd;               // Every device sees the data.
    assign inBus.wd  = prWd;
    assign outBus.wd = prWd;

    assign tcBus.wen  = prWe & hitTc;      // Only the hit device latches it.
    assign inBus.wen  = 1'b0;              // Input port is read only.
    assign outBus.wen = prWe & hitOut;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        prRd = '0;                         // Unmapped reads give zero.
        if (hitTc) begin
            prRd = tcBus.rd;
        end else if (hitIn) begin
            prRd = inBus.rd;
        end else if (hitOut) begin
            prRd = outBus.rd;
        end
    end

endmodule

`default_nettype wire

/* rtl/timerCounter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "devBus_consts.svh"

module timerCounter (
    input  logic    start,
    input  logic    rstN,
    devBusIf.device bus,
    output logic    irq
);
    import devBusPkg::*;

    wordT    ctrl;
    wordT    preset;
    wordT    count;
    tcStateT state;
    logic    ctrlWr;
    logic    presetWr;

    assign ctrlWr   = bus.wen && (bus.offset == `TC_CTRL);
    assign presetWr = bus.wen && (bus.offset == `TC_PRESET);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge start or negedge rstN) begin
        if (!rstN) begin
            ctrl <= '0;
        end else if (ctrlWr) begin
            ctrl <= bus.wd;
        end else if (state == tcInt && !ctrl[`TC_MODE_BIT]) begin
            ctrl[`TC_EN_BIT] <= 1'b0;      // One-shot disarms itself.
        end
    end

    always_ff @(posedge start or negedge rstN) begin
        if (!rstN) begin
            preset <= '0;
        end else if (presetWr) begin
            preset <= bus.wd;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Count FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge start or negedge rstN) begin
        if (!rstN) begin
            state <= tcIdle;
            count <= '0;
        end else if (ctrlWr) begin
            // A control write overrides whatever the FSM was doing.
            state <= bus.wd[`TC_EN_BIT] ? tcLoad : tcIdle;
        end else begin
            case (state)
                tcLoad: begin
                    count <= preset;
                    state <= tcCount;
                end
                tcCount: begin
                    if (count > 32'd1) begin
                        count <= count - 32'd1;
                    end else begin
                        count <= '0;       // Presets of 0 and 1 land here too.
                        state <= tcInt;
                    end
                end
                tcInt: begin
                    if (ctrl[`TC_MODE_BIT]) begin
                        state <= tcLoad;   // Auto-reload.
                    end
                end
                default: begin
                    state <= tcIdle;
                end
            endcase
        end
    end

    // Held in one-shot, single cycle in auto-reload.
    assign irq = (state == tcInt) && ctrl[`TC_IRQEN_BIT];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (bus.offset)
            `TC_CTRL:   bus.rd = ctrl;
            `TC_PRESET: bus.rd = preset;
            `TC_COUNT:  bus.rd = count;
            default:    bus.rd = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/gpioPort.sv */
`timescale 1ns/1ns
`default_nettype none

module gpioPort (
    input  logic            start,
    input  logic            rstN,
    devBusIf.device         inBus,
    devBusIf.device         outBus,
    input  devBusPkg::wordT inPins,
    output devBusPkg::wordT outPins
);
    import devBusPkg::*;

    wordT inMeta;       // First synchronizer stage.
    wordT inSync;       // Second stage, safe to read.
    wordT outReg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge start or negedge rstN) begin
        if (!rstN) begin
            inMeta <= '0;
            inSync <= '0;
        end else begin
            inMeta <= inPins;
            inSync <= inMeta;
        end
    end

    assign inBus.rd = inSync;      // Same word at every offset.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge start or negedge rstN) begin
        if (!rstN) begin
            outReg <= '0;
        end else if (outBus.wen) begin
            outReg <= outBus.wd;
        end
    end

    assign outPins   = outReg;     // Pins follow the register directly.
    assign outBus.rd = outReg;

endmodule

`default_nettype wire

/* rtl/deviceSubsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module deviceSubsystem (
    input  logic            start,
    input  logic            rstN,
    input  devBusPkg::wordT prAddr,
    input  devBusPkg::wordT prWd,
    input  logic            prWe,
    output devBusPkg::wordT prRd,
    input  devBusPkg::wordT inPins,
    output devBusPkg::wordT outPins,
    output logic            irq
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Device buses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    devBusIf tcBus ();
    devBusIf inBus ();
    devBusIf outBus ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bridge and devices
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    busBridge bridge (
        .prAddr (prAddr),
        .prWd   (prWd),
        .prWe   (prWe),
        .prRd   (prRd),
        .tcBus  (tcBus.bridge),
        .inBus  (inBus.bridge),
        .outBus (outBus.bridge)
    );

    timerCounter timer (
        .start (start),
        .rstN  (rstN),
        .bus   (tcBus.device),
        .irq   (irq)
    );

    // Both 32-bit ports live in one block.
    gpioPort gpio (
        .start   (start),
        .rstN    (rstN),
        .inBus   (inBus.device),
        .outBus  (outBus.device),
        .inPins  (inPins),
        .outPins (outPins)
    );

endmodule

`default_nettype wire

/* sim/deviceSubsystemTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "devBus_consts.svh"

module deviceSubsystemTb;
    import devBusPkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int STIM_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + RESET_CYCLES + 100;

    logic start;
    logic rstN;
    wordT prAddr;
    wordT prWd;
    logic prWe;
    wordT prRd;
    wordT inPins;
    wordT outPins;
    logic irq;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycleCount;

    // Reference model state.
    wordT    mCtrl;
    wordT    mPreset;
    wordT    mCount;
    tcStateT mState;
    wordT    mInMeta;
    wordT    mInSync;
    wordT    mOut;

    deviceSubsystem UUT (
        .start   (start),
        .rstN    (rstN),
        .prAddr  (prAddr),
        .prWd    (prWd),
        .prWe    (prWe),
        .prRd    (prRd),
        .inPins  (inPins),
        .outPins (outPins),
        .irq     (irq)
    );

    always #20 start = ~start;                 // 40 ns period.

    always @(posedge start) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        lsb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ 32'h8020_0003;   // Galois taps.
            end
            r = {r[30:0], lsb};
        end
        return r;
    endfunction

    // Mostly mapped devices, a quarter unmapped.
    function automatic wordT pickAddr();
        logic [31:0] dev;
        logic [31:0] r;
        dev = randBits(3);
        if (dev < 3) begin
            r = randBits(2);
            return {`DEV_TC, 2'b00, r[1:0]};
        end else if (dev == 3) begin
            r = randBits(4);
            return {`DEV_IN32, r[3:0]};
        end else if (dev < 6) begin
            r = randBits(4);
            return {`DEV_OUT32, r[3:0]};
        end
        return randBits(32);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic wordT modelRead(input wordT addr);
        if (addr[31:4] == `DEV_TC) begin
            case (addr[3:0])
                `TC_CTRL:   return mCtrl;
                `TC_PRESET: return mPreset;
                `TC_COUNT:  return mCount;
                default:    return '0;
            endcase
        end else if (addr[31:4] == `DEV_IN32) begin
            return mInSync;
        end else if (addr[31:4] == `DEV_OUT32) begin
            return mOut;
        end
        return '0;
    endfunction

    // One rising edge, using the inputs the DUT sees at that edge.
    task automatic modelStep();
        logic    tcHit;
        logic    ctrlWr;
        wordT    nCtrl;
        wordT    nCount;
        tcStateT nState;
        tcHit  = prWe && (prAddr[31:4] == `DEV_TC);
        ctrlWr = tcHit && (prAddr[3:0] == `TC_CTRL);
        nCtrl  = mCtrl;
        nCount = mCount;
        nState = mState;
        if (ctrlWr) begin
            nCtrl  = prWd;
            nState = prWd[`TC_EN_BIT] ? tcLoad : tcIdle;
        end else begin
            if (mState == tcInt && !mCtrl[`TC_MODE_BIT]) begin
                nCtrl[`TC_EN_BIT] = 1'b0;      // One-shot clears enable.
            end
            case (mState)
                tcLoad: begin
                    nCount = mPreset;
                    nState = tcCount;
                end
                tcCount: begin
                    nCount = (mCount > 1) ? mCount - 1 : '0;
                    nState = (mCount > 1) ? tcCount : tcInt;
                end
                tcInt: begin
                    nState = mCtrl[`TC_MODE_BIT] ? tcLoad : tcInt;
                end
                default: ;
            endcase
        end
        if (tcHit && prAddr[3:0] == `TC_PRESET) begin
            mPreset = prWd;
        end
        mCtrl   = nCtrl;
        mCount  = nCount;
        mState  = nState;
        mInSync = mInMeta;
        mInMeta = inPins;
        if (prWe && prAddr[31:4] == `DEV_OUT32) begin
            mOut = prWd;
        end
    endtask

    task automatic checkOutputs();
        wordT expRd;
        logic expIrq;
        expRd  = modelRead(prAddr);
        expIrq = (mState == tcInt) && mCtrl[`TC_IRQEN_BIT];
        checks = checks + 3;
        assert (prRd === expRd) else begin
            errors++;
            $display("CHECK FAILED prRd addr=%h exp=%h got=%h", prAddr, expRd, prRd);
        end
        assert (irq === expIrq) else begin
            errors++;
            $display("CHECK FAILED irq exp=%h got=%h", expIrq, irq);
        end
        assert (outPins === mOut) else begin
            errors++;
            $display("CHECK FAILED outPins exp=%h got=%h", mOut, outPins);
        end
    endtask

    // Drive on the rising edge, check in mid-cycle.
    task automatic runCycle(input wordT addr, input wordT wd, input logic we,
                            input wordT pins);
        @(posedge start);
        modelStep();
        prAddr <= addr;
        prWd   <= wd;
        prWe   <= we;
        inPins <= pins;
        @(negedge start);
        checkOutputs();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] op;
        wordT        addr;
        wordT        pins;
        start      = 1'b0;
        rstN       = 1'b0;
        prAddr     = '0;
        prWd       = '0;
        prWe       = 1'b0;
        inPins     = '0;
        lfsr       = 32'd12;
        errors     = 0;
        checks     = 0;
        cycleCount = 0;
        mCtrl      = '0;
        mPreset    = '0;
        mCount     = '0;
        mState     = tcIdle;
        mInMeta    = '0;
        mInSync    = '0;
        mOut       = '0;
        pins       = '0;

        repeat (RESET_CYCLES) @(posedge start);
        rstN <= 1'b1;

        // Every register reads zero straight after reset.
        for (int r = 0; r < 5; r++) begin
            addr = (r < 3) ? {`DEV_TC, r[3:0]} : (r == 3) ? {`DEV_IN32, 4'd0} : {`DEV_OUT32, 4'd0};
            runCycle(addr, '0, 1'b0, pins);
            checks = checks + 2;
            assert (prRd === '0) else begin
                errors++;
                $display("CHECK FAILED prRd after reset addr=%h exp=%h got=%h", addr, 32'h0, prRd);
            end
            assert (irq === 1'b0) else begin
                errors++;
                $display("CHECK FAILED irq after reset exp=%h got=%h", 1'b0, irq);
            end
        end

        for (int i = 0; i < STIM_CYCLES; i++) begin
            op   = randBits(2);
            addr = pickAddr();
            if (op == 1) begin
                // Small values give short timer periods.
                runCycle(addr, (addr[31:4] == `DEV_TC) ? randBits(4) : randBits(32), 1'b1, pins);
            end else if (op == 2) begin
                pins = randBits(32);
                runCycle(addr, '0, 1'b0, pins);
            end else begin
                runCycle(addr, '0, 1'b0, pins);
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+rtl
rtl/devBusPkg.sv
rtl/devBusIf.sv
rtl/busBridge.sv
rtl/timerCounter.sv
rtl/gpioPort.sv
rtl/deviceSubsystem.sv
sim/deviceSubsystemTb.sv

/* Bender.yml */
package:
  name: device_subsystem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/devBusPkg.sv
      - rtl/devBusIf.sv
      - rtl/busBridge.sv
      - rtl/timerCounter.sv
      - rtl/gpioPort.sv
      - rtl/deviceSubsystem.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - sim/deviceSubsystemTb.sv
